// File: include/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// geometry
`define ICACHE_ADDR_W 32
`define ICACHE_DATA_W 64
`define ICACHE_SETS 64
`define ICACHE_INDEX_W 6
`define ICACHE_TAG_W 21
`define ICACHE_OFFSET_W 5
`define ICACHE_BEATS 4

// register block, offsets decoded on the low address bits
`define ICACHE_CSR_W 32
`define ICACHE_CSR_AW 4
`define ICACHE_CSR_CTRL 4'h0 // bit0 enable, bit1 invalidate all
`define ICACHE_CSR_STATUS 4'h4 // bit0 flush busy
`define ICACHE_CSR_HITS 4'h8
`define ICACHE_CSR_MISSES 4'hC
`define ICACHE_ENABLE_RST 1'b1 // cache on out of reset

`endif

// File: hw/icache_pkg.sv
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

	typedef logic [`ICACHE_ADDR_W-1:0] addr_t; // fetch or line address
	typedef logic [`ICACHE_DATA_W-1:0] word_t; // one instruction beat
	typedef logic [`ICACHE_TAG_W-1:0] tag_t;
	typedef logic [`ICACHE_INDEX_W-1:0] index_t;
	typedef logic [$clog2(`ICACHE_BEATS)-1:0] beat_t; // beat within a line
	typedef logic [`ICACHE_CSR_W-1:0] csr_word_t;

	// fetch controller
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		REFILL,
		RESPOND,
		FLUSH
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: hw/icache_ways.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_ways (
	input wire clk,
	input wire rst_n,
	input wire icache_pkg::index_t lookup_index,
	input wire icache_pkg::tag_t lookup_tag,
	input wire icache_pkg::beat_t lookup_beat,
	output logic hit,
	output logic hit_way,
	output icache_pkg::word_t hit_data,
	output logic victim_way,
	input wire fill_we,
	input wire fill_way,
	input wire icache_pkg::index_t fill_index,
	input wire icache_pkg::tag_t fill_tag,
	input wire icache_pkg::beat_t fill_beat,
	input wire icache_pkg::word_t fill_data,
	input wire fill_last,
	input wire lru_touch,
	input wire lru_way,
	input wire inv_we,
	input wire icache_pkg::index_t inv_index
);
	import icache_pkg::*;

	tag_t tag_mem [2][`ICACHE_SETS];
	word_t data_mem [2][`ICACHE_SETS*`ICACHE_BEATS]; // addressed by {set, beat}
	logic [`ICACHE_SETS-1:0] valid [2];
	logic [`ICACHE_SETS-1:0] lru; // way to replace next
	logic [1:0] way_hit;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid[w][lookup_index] && (tag_mem[w][lookup_index] == lookup_tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1]; // both ways never hold the same tag
	assign hit_data = data_mem[hit_way][{lookup_index, lookup_beat}];

	// empty way first, way 0 before way 1
	always_comb begin
		if (!valid[0][lookup_index])
			victim_way = 1'b0;
		else if (!valid[1][lookup_index])
			victim_way = 1'b1;
		else
			victim_way = lru[lookup_index];
	end

	always_ff @(posedge clk) begin
		if (fill_we) begin
			data_mem[fill_way][{fill_index, fill_beat}] <= fill_data;
			if (fill_last)
				tag_mem[fill_way][fill_index] <= fill_tag; // tag lands with the last beat
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid[0] <= '0;
			valid[1] <= '0;
			lru <= '0;
		end else begin
			if (inv_we) begin
				valid[0][inv_index] <= 1'b0;
				valid[1][inv_index] <= 1'b0;
			end else if (fill_we && fill_last) begin
				valid[fill_way][fill_index] <= 1'b1;
			end
			if (lru_touch)
				lru[lookup_index] <= ~lru_way; // other way becomes least recent
		end
	end

endmodule

`default_nettype wire

// File: hw/icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_refill (
	input wire clk,
	input wire rst_n,
	input wire refill_start,
	input wire icache_pkg::addr_t refill_line,
	input wire icache_pkg::beat_t refill_beat,
	input wire refill_alloc,
	output logic mem_req_valid,
	input wire mem_req_ready,
	output icache_pkg::addr_t mem_req_addr,
	input wire mem_rvalid,
	input wire icache_pkg::word_t mem_rdata,
	output logic fill_we,
	output icache_pkg::beat_t fill_beat,
	output icache_pkg::word_t fill_data,
	output logic fill_last,
	output logic refill_done,
	output icache_pkg::word_t refill_word
);
	import icache_pkg::*;

	logic busy; // beats still expected
	beat_t cnt;
	beat_t want_q;
	logic alloc_q;
	addr_t line_q;

	assign mem_req_addr = line_q;
	assign fill_we = busy && mem_rvalid && alloc_q; // bypass fetches write nothing
	assign fill_beat = cnt;
	assign fill_data = mem_rdata;
	assign fill_last = (cnt == beat_t'(`ICACHE_BEATS-1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_req_valid <= 1'b0;
			busy <= 1'b0;
			cnt <= '0;
			refill_done <= 1'b0;
		end else begin
			refill_done <= 1'b0;
			if (refill_start) begin
				mem_req_valid <= 1'b1;
				busy <= 1'b1;
				cnt <= '0;
			end else begin
				if (mem_req_ready)
					mem_req_valid <= 1'b0; // request held until accepted
				if (busy && mem_rvalid) begin
					cnt <= cnt + 1'b1;
					if (fill_last) begin
						busy <= 1'b0;
						refill_done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (refill_start) begin
			line_q <= refill_line;
			want_q <= refill_beat;
			alloc_q <= refill_alloc;
		end
		if (busy && mem_rvalid && cnt == want_q)
			refill_word <= mem_rdata; // word for the cpu
	end

endmodule

`default_nettype wire

// File: hw/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_ctrl (
	input wire clk,
	input wire rst_n,
	input wire cpu_req_valid,
	input wire icache_pkg::addr_t cpu_req_addr,
	output logic cpu_resp_valid,
	output icache_pkg::word_t cpu_resp_data,
	input wire cache_enable,
	input wire flush_start,
	output logic flush_busy,
	output logic hit_event,
	output logic miss_event,
	output icache_pkg::index_t lookup_index,
	output icache_pkg::tag_t lookup_tag,
	output icache_pkg::beat_t lookup_beat,
	input wire hit,
	input wire hit_way,
	input wire icache_pkg::word_t hit_data,
	input wire victim_way,
	output logic fill_way,
	output icache_pkg::index_t fill_index,
	output icache_pkg::tag_t fill_tag,
	output logic lru_touch,
	output logic lru_way,
	output logic inv_we,
	output icache_pkg::index_t inv_index,
	output logic refill_start,
	output icache_pkg::addr_t refill_line,
	output icache_pkg::beat_t refill_beat,
	output logic refill_alloc,
	input wire refill_done,
	input wire icache_pkg::word_t refill_word
);
	import icache_pkg::*;

	ctrl_state_t state;
	addr_t req_addr;
	logic alloc_q; // this refill fills a way
	logic flush_pend; // invalidate asked while busy
	index_t flush_idx;
	logic hit_ok;

	assign lookup_tag = req_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
	assign lookup_index = req_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
	assign lookup_beat = req_addr[`ICACHE_OFFSET_W-1 -: $bits(beat_t)];
	assign fill_index = lookup_index;
	assign fill_tag = lookup_tag;

	assign hit_ok = (state == LOOKUP) && cache_enable && hit;
	assign cpu_resp_valid = hit_ok || (state == RESPOND);
	assign cpu_resp_data = (state == LOOKUP) ? hit_data : refill_word;

	assign refill_start = (state == LOOKUP) && !hit_ok;
	assign refill_line = {lookup_tag, lookup_index, {`ICACHE_OFFSET_W{1'b0}}};
	assign refill_beat = lookup_beat;
	assign refill_alloc = cache_enable;

	assign hit_event = hit_ok;
	assign miss_event = refill_start && cache_enable; // bypass counts as neither
	assign lru_touch = hit_ok || (refill_done && alloc_q);
	assign lru_way = (state == LOOKUP) ? hit_way : fill_way;

	assign inv_we = (state == FLUSH);
	assign inv_index = flush_idx;
	assign flush_busy = flush_pend || (state == FLUSH);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			flush_pend <= 1'b0;
			flush_idx <= '0;
		end else begin
			if (flush_start)
				flush_pend <= 1'b1;
			case (state)
				IDLE: begin
					if (flush_pend || flush_start) begin // flush wins over a fetch
						state <= FLUSH;
						flush_pend <= 1'b0;
						flush_idx <= '0;
					end else if (cpu_req_valid) begin
						state <= LOOKUP;
					end
				end
				LOOKUP: state <= hit_ok ? IDLE : REFILL;
				REFILL: if (refill_done) state <= RESPOND;
				RESPOND: state <= IDLE;
				FLUSH: begin
					flush_idx <= flush_idx + 1'b1;
					if (flush_idx == index_t'(`ICACHE_SETS-1))
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && cpu_req_valid)
			req_addr <= cpu_req_addr;
		if (state == LOOKUP) begin
			fill_way <= victim_way;
			alloc_q <= cache_enable;
		end
	end

endmodule

`default_nettype wire

// File: hw/icache_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_csr (
	input wire clk,
	input wire rst_n,
	input wire s_axi_awvalid,
	output logic s_axi_awready,
	input wire [`ICACHE_CSR_AW-1:0] s_axi_awaddr,
	input wire s_axi_wvalid,
	output logic s_axi_wready,
	input wire icache_pkg::csr_word_t s_axi_wdata,
	input wire [`ICACHE_CSR_W/8-1:0] s_axi_wstrb,
	output logic s_axi_bvalid,
	input wire s_axi_bready,
	output logic [1:0] s_axi_bresp,
	input wire s_axi_arvalid,
	output logic s_axi_arready,
	input wire [`ICACHE_CSR_AW-1:0] s_axi_araddr,
	output logic s_axi_rvalid,
	input wire s_axi_rready,
	output icache_pkg::csr_word_t s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic cache_enable,
	output logic flush_start,
	input wire flush_busy,
	input wire hit_event,
	input wire miss_event
);
	import icache_pkg::*;

	csr_word_t hits;
	csr_word_t misses;
	logic wr_go;
	logic rd_go;
	logic ctrl_wr;

	// address and data taken in the same cycle
	assign wr_go = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
	assign s_axi_awready = wr_go;
	assign s_axi_wready = wr_go;
	assign s_axi_bresp = 2'b00; // always OKAY
	assign ctrl_wr = wr_go && (s_axi_awaddr == `ICACHE_CSR_CTRL) && s_axi_wstrb[0];

	assign s_axi_arready = !s_axi_rvalid;
	assign rd_go = s_axi_arvalid && s_axi_arready;
	assign s_axi_rresp = 2'b00;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s_axi_bvalid <= 1'b0;
			cache_enable <= `ICACHE_ENABLE_RST;
			flush_start <= 1'b0;
		end else begin
			if (wr_go)
				s_axi_bvalid <= 1'b1;
			else if (s_axi_bready)
				s_axi_bvalid <= 1'b0;
			if (ctrl_wr)
				cache_enable <= s_axi_wdata[0];
			flush_start <= ctrl_wr && s_axi_wdata[1]; // one cycle, bit1 reads back 0
		end
	end

	// counters saturate, any write clears
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hits <= '0;
			misses <= '0;
		end else begin
			if (wr_go && s_axi_awaddr == `ICACHE_CSR_HITS && |s_axi_wstrb)
				hits <= '0;
			else if (hit_event && hits != '1)
				hits <= hits + 1'b1;
			if (wr_go && s_axi_awaddr == `ICACHE_CSR_MISSES && |s_axi_wstrb)
				misses <= '0;
			else if (miss_event && misses != '1)
				misses <= misses + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			s_axi_rvalid <= 1'b0;
		else if (rd_go)
			s_axi_rvalid <= 1'b1;
		else if (s_axi_rready)
			s_axi_rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rd_go) begin
			case (s_axi_araddr)
				`ICACHE_CSR_CTRL: s_axi_rdata <= csr_word_t'(cache_enable);
				`ICACHE_CSR_STATUS: s_axi_rdata <= csr_word_t'(flush_busy);
				`ICACHE_CSR_HITS: s_axi_rdata <= hits;
				`ICACHE_CSR_MISSES: s_axi_rdata <= misses;
				default: s_axi_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_top (
	input wire clk,
	input wire rst_n,
	input wire cpu_req_valid,
	input wire icache_pkg::addr_t cpu_req_addr,
	output icache_pkg::word_t cpu_resp_data,
	output logic cpu_resp_valid,
	output logic mem_req_valid,
	input wire mem_req_ready,
	output icache_pkg::addr_t mem_req_addr,
	input wire mem_rvalid,
	input wire icache_pkg::word_t mem_rdata,
	input wire s_axi_awvalid,
	output logic s_axi_awready,
	input wire [`ICACHE_CSR_AW-1:0] s_axi_awaddr,
	input wire s_axi_wvalid,
	output logic s_axi_wready,
	input wire icache_pkg::csr_word_t s_axi_wdata,
	input wire [`ICACHE_CSR_W/8-1:0] s_axi_wstrb,
	output logic s_axi_bvalid,
	input wire s_axi_bready,
	output logic [1:0] s_axi_bresp,
	input wire s_axi_arvalid,
	output logic s_axi_arready,
	input wire [`ICACHE_CSR_AW-1:0] s_axi_araddr,
	output logic s_axi_rvalid,
	input wire s_axi_rready,
	output icache_pkg::csr_word_t s_axi_rdata,
	output logic [1:0] s_axi_rresp
);

	// csr and controller
	logic cache_enable, flush_start, flush_busy, hit_event, miss_event;
	// lookup and storage update
	icache_pkg::index_t lookup_index, fill_index, inv_index;
	icache_pkg::tag_t lookup_tag, fill_tag;
	icache_pkg::beat_t lookup_beat, fill_beat, refill_beat;
	icache_pkg::word_t hit_data, fill_data, refill_word;
	logic hit, hit_way, victim_way, fill_we, fill_way, fill_last;
	logic lru_touch, lru_way, inv_we;
	// refill handoff
	icache_pkg::addr_t refill_line;
	logic refill_start, refill_alloc, refill_done;

	icache_csr u_csr (.*);
	icache_ctrl u_ctrl (.*);
	icache_ways u_ways (.*);
	icache_refill u_refill (.*);

endmodule

`default_nettype wire

// File: test/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_tb;
	import icache_pkg::*;

	localparam int unsigned FETCH_TIMEOUT = 200; // cycles per fetch
	localparam int unsigned CSR_TIMEOUT = 20;
	localparam int unsigned POLL_LIMIT = 100; // status reads

	logic clk;
	logic rst_n;
	logic cpu_req_valid;
	addr_t cpu_req_addr;
	logic cpu_resp_valid;
	word_t cpu_resp_data;
	logic mem_req_valid;
	logic mem_req_ready;
	addr_t mem_req_addr;
	logic mem_rvalid;
	word_t mem_rdata;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [`ICACHE_CSR_AW-1:0] s_axi_awaddr;
	logic s_axi_wvalid;
	logic s_axi_wready;
	csr_word_t s_axi_wdata;
	logic [`ICACHE_CSR_W/8-1:0] s_axi_wstrb;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [1:0] s_axi_bresp;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [`ICACHE_CSR_AW-1:0] s_axi_araddr;
	logic s_axi_rvalid;
	logic s_axi_rready;
	csr_word_t s_axi_rdata;
	logic [1:0] s_axi_rresp;

	icache_top u_dut (.*);

	always #20 clk = ~clk; // 40 ns period

	// upper word inverted beat address, lower word the address
	function automatic word_t mem_beat(input addr_t a);
		addr_t aligned;
		aligned = a & ~addr_t'(7);
		return {~aligned, aligned};
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual)
			abort_run($sformatf("ERROR %s: expected %0h, actual %0h", what, expected, actual));
	endtask

	// one fetch, memory side served in the same loop
	task automatic fetch(input addr_t addr, input logic [31:0] exp_reqs, input string test);
		int unsigned edges;
		int unsigned reqs;
		int unsigned beats;
		int unsigned gap;
		logic burst;
		logic done;
		logic hs_seen;
		logic beat_seen;
		addr_t line;
		word_t data;
		edges = 0;
		reqs = 0;
		beats = 0;
		burst = 1'b0;
		done = 1'b0;
		line = '0;
		data = '0;
		gap = $urandom_range(3, 0);
		@(posedge clk);
		#1;
		cpu_req_valid = 1'b1;
		cpu_req_addr = addr;
		while (!done) begin
			@(negedge clk);
			if (cpu_resp_valid) begin
				done = 1'b1;
				data = cpu_resp_data;
			end else begin
				hs_seen = mem_req_valid && mem_req_ready; // taken at the next edge
				beat_seen = mem_rvalid;
				if (hs_seen) begin
					line = mem_req_addr;
					check_value({test, " line"}, 64'(addr & ~addr_t'(31)), 64'(line));
				end
				@(posedge clk);
				edges++;
				if (edges > FETCH_TIMEOUT)
					abort_run($sformatf("%s: no fetch response before the timeout", test));
				#1;
				if (beat_seen)
					beats++;
				if (burst && beats == `ICACHE_BEATS) begin
					burst = 1'b0;
					gap = $urandom_range(3, 0);
				end
				if (hs_seen) begin
					reqs++;
					burst = 1'b1;
					beats = 0;
					mem_req_ready = 1'b0;
					gap = $urandom_range(3, 0);
				end else if (!burst && mem_req_valid && !mem_req_ready) begin
					if (gap == 0)
						mem_req_ready = 1'b1;
					else
						gap--;
				end
				mem_rvalid = 1'b0;
				if (burst && beats < `ICACHE_BEATS) begin
					if (gap == 0) begin
						mem_rvalid = 1'b1;
						mem_rdata = mem_beat(line + addr_t'(beats * 8));
						gap = $urandom_range(3, 0); // gap before the next beat
					end else begin
						gap--;
					end
				end
			end
		end
		check_value({test, " data"}, mem_beat(addr), data);
		check_value({test, " requests"}, 64'(exp_reqs), 64'(reqs));
		if (exp_reqs == 0)
			check_value({test, " latency"}, 64'd1, 64'(edges)); // one edge after sampling
		@(posedge clk);
		#1;
		check_value({test, " response pulse"}, 64'd0, 64'(cpu_resp_valid)); // one cycle only
		cpu_req_valid = 1'b0;
	endtask

	task automatic csr_write(input logic [`ICACHE_CSR_AW-1:0] addr, input csr_word_t data,
			input string test);
		int unsigned waited;
		waited = 0;
		@(posedge clk);
		#1;
		s_axi_awvalid = 1'b1;
		s_axi_awaddr = addr;
		s_axi_wvalid = 1'b1;
		s_axi_wdata = data;
		s_axi_wstrb = '1;
		s_axi_bready = 1'b1;
		@(negedge clk);
		while (!(s_axi_awready && s_axi_wready)) begin
			waited++;
			if (waited > CSR_TIMEOUT)
				abort_run("register write was never accepted");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		waited = 0;
		@(negedge clk);
		while (!s_axi_bvalid) begin
			waited++;
			if (waited > CSR_TIMEOUT)
				abort_run("no write response arrived for a register write");
			@(negedge clk);
		end
		check_value({test, " bresp"}, 64'd0, 64'(s_axi_bresp));
		@(posedge clk);
		#1;
		s_axi_bready = 1'b0;
	endtask

	task automatic csr_read(input logic [`ICACHE_CSR_AW-1:0] addr, output csr_word_t value,
			input string test);
		int unsigned waited;
		waited = 0;
		@(posedge clk);
		#1;
		s_axi_arvalid = 1'b1;
		s_axi_araddr = addr;
		s_axi_rready = 1'b1;
		@(negedge clk);
		while (!s_axi_arready) begin
			waited++;
			if (waited > CSR_TIMEOUT)
				abort_run("register read address was never accepted");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		s_axi_arvalid = 1'b0;
		waited = 0;
		@(negedge clk);
		while (!s_axi_rvalid) begin
			waited++;
			if (waited > CSR_TIMEOUT)
				abort_run("no read data arrived for a register read");
			@(negedge clk);
		end
		value = s_axi_rdata;
		check_value({test, " rresp"}, 64'd0, 64'(s_axi_rresp));
		@(posedge clk);
		#1;
		s_axi_rready = 1'b0;
	endtask

	task automatic poll_until(input logic [`ICACHE_CSR_AW-1:0] addr, input csr_word_t mask,
			input csr_word_t expected, input string test);
		int unsigned polls;
		csr_word_t value;
		polls = 0;
		csr_read(addr, value, test);
		while ((value & mask) != expected) begin
			polls++;
			if (polls > POLL_LIMIT)
				abort_run($sformatf("%s: register never reached the awaited value", test));
			csr_read(addr, value, test);
		end
	endtask

	initial begin
		int fd;
		int n;
		int unsigned ops;
		string line_buf;
		string test;
		logic [8*32-1:0] name_buf;
		logic [7:0] op;
		logic [31:0] t_addr;
		logic [31:0] t_data;
		logic [31:0] t_exp;
		csr_word_t value;
		void'($urandom(32'he62c)); // seeds every later draw
		clk = 1'b0;
		rst_n = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req_addr = '0;
		mem_req_ready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		s_axi_awvalid = 1'b0;
		s_axi_awaddr = '0;
		s_axi_wvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_bready = 1'b0;
		s_axi_arvalid = 1'b0;
		s_axi_araddr = '0;
		s_axi_rready = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		ops = 0;
		fd = $fopen("test/icache_trace.txt", "r");
		if (fd == 0)
			abort_run("could not open the trace file test/icache_trace.txt");
		while ($fgets(line_buf, fd) != 0) begin
			name_buf = '0;
			op = 8'h00;
			n = $sscanf(line_buf, "%c %h %h %h %s", op, t_addr, t_data, t_exp, name_buf);
			if (n == 5) begin
				test = string'(name_buf);
				ops++;
				case (op)
					"F": fetch(t_addr, t_exp, test);
					"W": csr_write(t_addr[`ICACHE_CSR_AW-1:0], t_data, test);
					"R": begin
						csr_read(t_addr[`ICACHE_CSR_AW-1:0], value, test);
						check_value(test, 64'(t_exp), 64'(value));
					end
					"P": poll_until(t_addr[`ICACHE_CSR_AW-1:0], t_data, t_exp, test);
					default: abort_run($sformatf("unknown opcode %c in the trace file", op));
				endcase
			end else if (n > 0 && op != "#" && op != 8'h0a) begin
				abort_run("malformed line in the trace file");
			end
		end
		$fclose(fd);
		if (ops > 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			abort_run("the trace file held no operations");
		end
	end

endmodule

`default_nettype wire

// File: rvseed_icache.f
+incdir+include
hw/icache_pkg.sv
hw/icache_ways.sv
hw/icache_refill.sv
hw/icache_ctrl.sv
hw/icache_csr.sv
hw/icache_top.sv
test/icache_tb.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP      ?= icache_tb
FILELIST ?= rvseed_icache.f
OBJ_DIR  ?= obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# runs from the project root so the trace path resolves
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: test/icache_trace.txt
# op addr data expect name, all numbers hex
# F fetch (expect = memory requests), W csr write, R csr read, P poll until (read & data) == expect
F 00001060 0 1 miss_a
F 00001068 0 0 hit_a_beat1
F 00001078 0 0 hit_a_beat3
F 00002060 0 1 miss_b
F 00001070 0 0 hit_a_again
F 00003060 0 1 miss_c_evicts_b
F 00001060 0 0 hit_a_after_c
F 00002068 0 1 miss_b_evicted
R 8 0 4 hits_after_lru
R c 0 4 misses_after_lru
W 0 0 0 disable_cache
R 0 0 0 ctrl_disabled
F 00004000 0 1 bypass_first
F 00004008 0 1 bypass_second
F 00004000 0 1 bypass_third
F 00001060 0 1 bypass_cached_a
W 0 1 0 enable_cache
F 00004010 0 1 enabled_first_miss
F 00004018 0 0 enabled_hit
R 8 0 5 hits_after_bypass
R c 0 5 misses_after_bypass
W 8 0 0 clear_hits
R 8 0 0 hits_cleared
W c 0 0 clear_misses
R c 0 0 misses_cleared
W 0 3 0 invalidate_all
R 4 0 1 flush_busy_seen
P 4 1 0 flush_finished
R 0 0 1 ctrl_inv_self_clear
F 00001060 0 1 a_after_invalidate
F 00004010 0 1 line_after_invalidate
F 00001068 0 0 hit_after_refill
R 8 0 1 hits_final
R c 0 2 misses_final
